/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_l2
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx '=== PASS ===' $(LOG)

check: run
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* soc_l2_pkg.sv */
package soc_l2_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int BE_WIDTH       = 4;
    // Byte offset inside a word below the bank and row fields
    localparam int BYTE_OFF_WIDTH = 2;

    ////////////////////
    // L2 organisation
    ////////////////////
    localparam int NR_L2_BANKS    = 4;
    // Same depth for every interleaved bank and the private bank
    localparam int BANK_WORDS     = 16;
    localparam int BANK_SEL_WIDTH = 2;
    localparam int ROW_WIDTH      = 4;

    // Request buffer between decoder and banks
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    ////////////////////
    // Memory map
    ////////////////////
    // Legacy alias maps 0x000xxxxx onto 0x1c0xxxxx
    localparam int PREFIX_WIDTH = 12;
    localparam logic [PREFIX_WIDTH-1:0] ALIAS_PREFIX = 12'h000;
    localparam logic [PREFIX_WIDTH-1:0] SOC_PREFIX   = 12'h1c0;

    // Word-interleaved region over four banks of sixteen words
    localparam logic [ADDR_WIDTH-1:0] L2_INTLV_START = 32'h1c01_0000;
    localparam logic [ADDR_WIDTH-1:0] L2_INTLV_END   = 32'h1c01_00ff;
    // Contiguous private bank
    localparam logic [ADDR_WIDTH-1:0] PRIVATE_START  = 32'h1c00_0000;
    localparam logic [ADDR_WIDTH-1:0] PRIVATE_END    = 32'h1c00_003f;

    ////////////////////
    // Types
    ////////////////////
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } soc_op_e;

    // TGT_NONE covers everything outside both regions
    typedef enum logic [1:0] {
        TGT_L2_INTLV = 2'd0,
        TGT_PRIVATE  = 2'd1,
        TGT_NONE     = 2'd2
    } soc_target_e;

    // Request as issued by the master
    typedef struct packed {
        soc_op_e                 op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [BE_WIDTH-1:0]     be;
        logic [DATA_WIDTH-1:0]   wdata;
    } soc_req_t;

    // Request after address decode with bank and row resolved
    typedef struct packed {
        soc_target_e               target;
        soc_op_e                   op;
        logic [BANK_SEL_WIDTH-1:0] bank;
        logic [ROW_WIDTH-1:0]      row;
        logic [BE_WIDTH-1:0]       be;
        logic [DATA_WIDTH-1:0]     wdata;
    } soc_routed_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  err;
    } soc_rsp_t;

endpackage

/* soc_l2_targets.sv */
module soc_l2_targets (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Decoded requests from the FIFO
    input  logic                        req_valid_i,
    input  soc_l2_pkg::soc_routed_req_t req_i,
    output logic                        req_ready_o,
    // Response towards the master
    output logic                        rsp_valid_o,
    output soc_l2_pkg::soc_rsp_t        rsp_o,
    input  logic                        rsp_ready_i
);

    // Interleaved banks indexed by bank then row
    logic [soc_l2_pkg::DATA_WIDTH-1:0]
        intlv_mem [soc_l2_pkg::NR_L2_BANKS][soc_l2_pkg::BANK_WORDS];
    logic [soc_l2_pkg::DATA_WIDTH-1:0] priv_mem [soc_l2_pkg::BANK_WORDS];

    logic [soc_l2_pkg::DATA_WIDTH-1:0] intlv_rdata;
    logic [soc_l2_pkg::DATA_WIDTH-1:0] priv_rdata;
    logic                              req_fire;
    logic                              rsp_valid_q;
    soc_l2_pkg::soc_rsp_t              rsp_q;
    soc_l2_pkg::soc_rsp_t              rsp_d;

    // Byte-wise merge of write data into a stored word
    function automatic logic [soc_l2_pkg::DATA_WIDTH-1:0] merge_bytes(
        input logic [soc_l2_pkg::DATA_WIDTH-1:0] old_word,
        input logic [soc_l2_pkg::DATA_WIDTH-1:0] new_word,
        input logic [soc_l2_pkg::BE_WIDTH-1:0]   be
    );
        logic [soc_l2_pkg::DATA_WIDTH-1:0] res;
        res = old_word;
        for (int b = 0; b < soc_l2_pkg::BE_WIDTH; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Take a new request while the response slot is free or draining
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    // Asynchronous read of the addressed word gives the old value on a write
    assign intlv_rdata = intlv_mem[req_i.bank][req_i.row];
    assign priv_rdata  = priv_mem[req_i.row];

    ////////////////////
    // Bank write
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (req_fire && req_i.op == soc_l2_pkg::OP_WRITE) begin
            if (req_i.target == soc_l2_pkg::TGT_L2_INTLV) begin
                intlv_mem[req_i.bank][req_i.row] <=
                    merge_bytes(intlv_rdata, req_i.wdata, req_i.be);
            end else if (req_i.target == soc_l2_pkg::TGT_PRIVATE) begin
                priv_mem[req_i.row] <= merge_bytes(priv_rdata, req_i.wdata, req_i.be);
            end
            // Unmapped writes are dropped
        end
    end

    ////////////////////
    // Response
    ////////////////////
    always_comb begin
        rsp_d.rdata = '0;
        rsp_d.err   = 1'b0;
        case (req_i.target)
            soc_l2_pkg::TGT_L2_INTLV: begin
                if (req_i.op == soc_l2_pkg::OP_READ) begin
                    rsp_d.rdata = intlv_rdata;
                end
            end
            soc_l2_pkg::TGT_PRIVATE: begin
                if (req_i.op == soc_l2_pkg::OP_READ) begin
                    rsp_d.rdata = priv_rdata;
                end
            end
            default: begin
                // Error response with read data left at zero
                rsp_d.err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    // Response held steady under back-pressure from the master
    assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

/* soc_l2_top.sv */
module soc_l2_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // Master request channel
    input  logic                 req_valid_i,
    input  soc_l2_pkg::soc_req_t req_i,
    output logic                 req_ready_o,
    // Master response channel
    output logic                 rsp_valid_o,
    output soc_l2_pkg::soc_rsp_t rsp_o,
    input  logic                 rsp_ready_i
);

    logic                        dec_valid;
    soc_l2_pkg::soc_routed_req_t dec_req;
    logic                        dec_ready;
    logic                        fifo_valid;
    soc_l2_pkg::soc_routed_req_t fifo_req;
    logic                        fifo_ready;

    ////////////////////
    // Alias and decode
    ////////////////////
    soc_req_decoder i_soc_req_decoder (
        .clk_i,
        .reset_i,
        .req_valid_i,
        .req_i,
        .req_ready_o,
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req),
        .dec_ready_i (dec_ready)
    );

    // Decouples decode from the banks
    soc_req_fifo i_soc_req_fifo (
        .clk_i,
        .reset_i,
        .in_valid_i  (dec_valid),
        .in_req_i    (dec_req),
        .in_ready_o  (dec_ready),
        .out_valid_o (fifo_valid),
        .out_req_o   (fifo_req),
        .out_ready_i (fifo_ready)
    );

    ////////////////////
    // L2 banks
    ////////////////////
    soc_l2_targets i_soc_l2_targets (
        .clk_i,
        .reset_i,
        .req_valid_i (fifo_valid),
        .req_i       (fifo_req),
        .req_ready_o (fifo_ready),
        .rsp_valid_o,
        .rsp_o,
        .rsp_ready_i
    );

endmodule

/* soc_req_decoder.sv */
module soc_req_decoder (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Master side
    input  logic                        req_valid_i,
    input  soc_l2_pkg::soc_req_t        req_i,
    output logic                        req_ready_o,
    // Decoded request towards the FIFO
    output logic                        dec_valid_o,
    output soc_l2_pkg::soc_routed_req_t dec_req_o,
    input  logic                        dec_ready_i
);

    logic                          dec_valid_q;
    soc_l2_pkg::soc_routed_req_t   dec_req_q;
    soc_l2_pkg::soc_routed_req_t   dec_req_d;
    logic [soc_l2_pkg::ADDR_WIDTH-1:0] addr_remap;
    logic                          req_fire;

    ////////////////////
    // Legacy alias
    ////////////////////
    always_comb begin
        addr_remap = req_i.addr;
        // Only the top prefix is replaced and the offset passes unchanged
        if (req_i.addr[soc_l2_pkg::ADDR_WIDTH-1 -: soc_l2_pkg::PREFIX_WIDTH] ==
            soc_l2_pkg::ALIAS_PREFIX) begin
            addr_remap[soc_l2_pkg::ADDR_WIDTH-1 -: soc_l2_pkg::PREFIX_WIDTH] =
                soc_l2_pkg::SOC_PREFIX;
        end
    end

    ////////////////////
    // Region decode
    ////////////////////
    always_comb begin
        dec_req_d.op    = req_i.op;
        dec_req_d.be    = req_i.be;
        dec_req_d.wdata = req_i.wdata;
        // Default is an unmapped access with bank and row unused
        dec_req_d.target = soc_l2_pkg::TGT_NONE;
        dec_req_d.bank   = '0;
        dec_req_d.row    = '0;
        if (addr_remap >= soc_l2_pkg::L2_INTLV_START &&
            addr_remap <= soc_l2_pkg::L2_INTLV_END) begin
            // Consecutive words rotate over the banks
            dec_req_d.target = soc_l2_pkg::TGT_L2_INTLV;
            dec_req_d.bank   = addr_remap[soc_l2_pkg::BYTE_OFF_WIDTH +:
                                          soc_l2_pkg::BANK_SEL_WIDTH];
            dec_req_d.row    = addr_remap[soc_l2_pkg::BYTE_OFF_WIDTH +
                                          soc_l2_pkg::BANK_SEL_WIDTH +:
                                          soc_l2_pkg::ROW_WIDTH];
        end else if (addr_remap >= soc_l2_pkg::PRIVATE_START &&
                     addr_remap <= soc_l2_pkg::PRIVATE_END) begin
            // Single contiguous bank where the word index is the row
            dec_req_d.target = soc_l2_pkg::TGT_PRIVATE;
            dec_req_d.row    = addr_remap[soc_l2_pkg::BYTE_OFF_WIDTH +:
                                          soc_l2_pkg::ROW_WIDTH];
        end
    end

    ////////////////////
    // Output register
    ////////////////////
    // Accept when empty or when the held entry leaves this cycle
    assign req_ready_o = !dec_valid_q || dec_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_q <= 1'b0;
        end else if (req_fire) begin
            dec_valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            dec_req_q <= dec_req_d;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_req_o   = dec_req_q;

    // Stalled output keeps valid and payload until the FIFO takes it
    assert property (@(posedge clk_i) disable iff (reset_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_req_o));

endmodule

/* soc_req_fifo.sv */
module soc_req_fifo (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Write side
    input  logic                        in_valid_i,
    input  soc_l2_pkg::soc_routed_req_t in_req_i,
    output logic                        in_ready_o,
    // Read side
    output logic                        out_valid_o,
    output soc_l2_pkg::soc_routed_req_t out_req_o,
    input  logic                        out_ready_i
);

    soc_l2_pkg::soc_routed_req_t             fifo_mem [soc_l2_pkg::FIFO_DEPTH];
    logic [soc_l2_pkg::FIFO_PTR_WIDTH-1:0]   rd_ptr_q;
    logic [soc_l2_pkg::FIFO_PTR_WIDTH-1:0]   wr_ptr_q;
    logic [soc_l2_pkg::FIFO_CNT_WIDTH-1:0]   count_q;
    logic                                    push;
    logic                                    pop;
    logic                                    full;
    logic                                    empty;

    assign full  = (count_q == soc_l2_pkg::FIFO_CNT_WIDTH'(soc_l2_pkg::FIFO_DEPTH));
    assign empty = (count_q == '0);

    // A new entry shows up one cycle after the push
    assign in_ready_o  = !full;
    assign out_valid_o = !empty;
    assign out_req_o   = fifo_mem[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    ////////////////////
    // Pointers and count
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == soc_l2_pkg::FIFO_PTR_WIDTH'(soc_l2_pkg::FIFO_DEPTH - 1))
                            ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == soc_l2_pkg::FIFO_PTR_WIDTH'(soc_l2_pkg::FIFO_DEPTH - 1))
                            ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= in_req_i;
        end
    end

    // A push never lands on an unread entry
    assert property (@(posedge clk_i) disable iff (reset_i)
        push |-> empty || wr_ptr_q != rd_ptr_q);
    // A pop never reads a slot that holds no entry
    assert property (@(posedge clk_i) disable iff (reset_i)
        pop |-> full || wr_ptr_q != rd_ptr_q);

endmodule

/* tb.f */
soc_l2_pkg.sv
soc_req_decoder.sv
soc_req_fifo.sv
soc_l2_targets.sv
soc_l2_top.sv
tb_soc_l2_checker.sv
tb_soc_l2.sv

/* tb_soc_l2.sv */
module tb_soc_l2;

    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 94995;
    // 128 + 17 + 64 + 7 + 200 requests over the five tests
    localparam int TOTAL_REQS = 416;

    logic                 clk_i = 1'b0;
    logic                 reset_i;
    logic                 req_valid_i;
    soc_l2_pkg::soc_req_t req_i;
    logic                 req_ready_o;
    logic                 rsp_valid_o;
    soc_l2_pkg::soc_rsp_t rsp_o;
    logic                 rsp_ready_i;

    int   err_count;
    int   rsp_count;
    int   pending;
    int   sent_count = 0;
    logic bp_en = 1'b0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    soc_l2_top i_soc_l2_top (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    tb_soc_l2_checker i_checker (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_i (req_ready_o),
        .rsp_valid_i (rsp_valid_o),
        .rsp_i       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .err_count_o (err_count),
        .rsp_count_o (rsp_count),
        .pending_o   (pending)
    );

    // Random response back-pressure while enabled
    initial begin
        rsp_ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            rsp_ready_i = bp_en ? ($urandom_range(0, 1) == 1) : 1'b1;
        end
    end

    ////////////////////
    // Bus helpers
    ////////////////////
    // Called at a falling edge and returns at the falling edge after the transfer
    task automatic send_req(input soc_l2_pkg::soc_op_e op, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata);
        req_i.op    = op;
        req_i.addr  = addr;
        req_i.be    = be;
        req_i.wdata = wdata;
        req_valid_i = 1'b1;
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        @(negedge clk_i);
        req_valid_i = 1'b0;
        sent_count  = sent_count + 1;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        send_req(soc_l2_pkg::OP_WRITE, addr, be, wdata);
    endtask

    task automatic read_word(input logic [31:0] addr);
        send_req(soc_l2_pkg::OP_READ, addr, 4'hf, 32'h0);
    endtask

    task automatic wait_drained();
        while (pending != 0) @(negedge clk_i);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("Test %0d %s: %0d mismatches", num, name, err_count - err_before);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_interleaved();
        int err_before;
        err_before = err_count;
        for (int i = 0; i < 64; i++) begin
            write_word(soc_l2_pkg::L2_INTLV_START + 4 * i, 4'hf,
                       32'h5a00_0000 + i * 32'h0001_0203);
        end
        for (int i = 0; i < 64; i++) begin
            read_word(soc_l2_pkg::L2_INTLV_START + 4 * i);
        end
        wait_drained();
        report_test(1, "interleaved write and read back", err_before);
    endtask

    task automatic test_byte_enables();
        int          err_before;
        logic [31:0] addr;
        err_before = err_count;
        addr = soc_l2_pkg::PRIVATE_START + 32'h14;
        write_word(addr, 4'hf, 32'ha5a5_5a5a);
        for (int i = 0; i < 8; i++) begin
            write_word(addr, 4'($urandom_range(0, 15)), $urandom());
            read_word(addr);
        end
        wait_drained();
        report_test(2, "private bank byte enables", err_before);
    endtask

    task automatic test_alias();
        int          err_before;
        logic [31:0] soc_addr;
        logic [31:0] alias_addr;
        err_before = err_count;
        for (int i = 0; i < 16; i++) begin
            soc_addr   = soc_l2_pkg::PRIVATE_START + 4 * i;
            alias_addr = {soc_l2_pkg::ALIAS_PREFIX, soc_addr[19:0]};
            // Write through the alias and read through the SoC address
            write_word(alias_addr, 4'hf, 32'h0a11_0000 + i);
            read_word(soc_addr);
            // And the other way round
            write_word(soc_addr, 4'hf, 32'h50c0_0000 + i);
            read_word(alias_addr);
        end
        wait_drained();
        report_test(3, "legacy alias", err_before);
    endtask

    task automatic test_unmapped();
        int          err_before;
        logic [31:0] bad_addr [3];
        err_before = err_count;
        bad_addr[0] = 32'h2000_0000;
        bad_addr[1] = 32'h1c02_0000;
        // Aliases onto the word just past the interleaved region
        bad_addr[2] = 32'h0001_0100;
        for (int i = 0; i < 3; i++) begin
            write_word(bad_addr[i], 4'hf, 32'hdead_0000 + i);
            read_word(bad_addr[i]);
        end
        read_word(soc_l2_pkg::L2_INTLV_START);
        wait_drained();
        report_test(4, "unmapped addresses", err_before);
    endtask

    task automatic test_random_mix();
        int          err_before;
        int unsigned region;
        logic [31:0] addr;
        err_before = err_count;
        bp_en = 1'b1;
        for (int n = 0; n < 200; n++) begin
            region = $urandom_range(0, 3);
            case (region)
                0: addr = soc_l2_pkg::L2_INTLV_START + 4 * $urandom_range(0, 63);
                1: addr = soc_l2_pkg::PRIVATE_START + 4 * $urandom_range(0, 15);
                2: addr = 32'h0000_0000 + 4 * $urandom_range(0, 15);
                default: addr = 32'h3000_0000 + 4 * $urandom_range(0, 255);
            endcase
            if ($urandom_range(0, 1) == 1) begin
                write_word(addr, 4'($urandom_range(0, 15)), $urandom());
            end else begin
                read_word(addr);
            end
            repeat ($urandom_range(0, 2)) @(negedge clk_i);
        end
        wait_drained();
        bp_en = 1'b0;
        report_test(5, "random mix with back-pressure", err_before);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        void'($urandom(SEED));
        req_valid_i = 1'b0;
        req_i       = '0;
        reset_i     = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        test_interleaved();
        test_byte_enables();
        test_alias();
        test_unmapped();
        test_random_mix();
        if (pending != 0) begin
            $display("%0d responses still outstanding at the end of the run", pending);
        end
        if (rsp_count != sent_count) begin
            $display("Sent %0d requests but saw %0d responses", sent_count, rsp_count);
        end
        $display("Summary: %0d requests, %0d responses, %0d errors, %0d outstanding",
                 sent_count, rsp_count, err_count, pending);
        if (err_count == 0 && pending == 0 && rsp_count == sent_count) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized for the whole request count
    initial begin
        #(TOTAL_REQS * 40 * CLK_PERIOD);
        $display("Timeout: the run did not complete within %0d time units",
                 TOTAL_REQS * 40 * CLK_PERIOD);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tb_soc_l2_checker.sv */
module tb_soc_l2_checker (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // Request channel as seen at the DUT boundary
    input  logic                 req_valid_i,
    input  soc_l2_pkg::soc_req_t req_i,
    input  logic                 req_ready_i,
    // Response channel as seen at the DUT boundary
    input  logic                 rsp_valid_i,
    input  soc_l2_pkg::soc_rsp_t rsp_i,
    input  logic                 rsp_ready_i,
    // Running counts for the testbench top
    output int                   err_count_o,
    output int                   rsp_count_o,
    output int                   pending_o
);

    // Memory model with one array per region indexed by word offset
    logic [soc_l2_pkg::DATA_WIDTH-1:0]
        intlv_model [soc_l2_pkg::NR_L2_BANKS * soc_l2_pkg::BANK_WORDS];
    logic [soc_l2_pkg::DATA_WIDTH-1:0] priv_model [soc_l2_pkg::BANK_WORDS];

    // Expected responses in request order
    soc_l2_pkg::soc_rsp_t exp_q [$];

    ////////////////////
    // Reference model
    ////////////////////
    function automatic soc_l2_pkg::soc_rsp_t expect_rsp(input soc_l2_pkg::soc_req_t req);
        logic [soc_l2_pkg::ADDR_WIDTH-1:0] addr;
        logic [soc_l2_pkg::ADDR_WIDTH-1:0] offset;
        logic [soc_l2_pkg::DATA_WIDTH-1:0] mask;
        logic [5:0]                        iidx;
        logic [3:0]                        pidx;
        soc_l2_pkg::soc_rsp_t              rsp;
        addr = req.addr;
        // Legacy prefix seen as the SoC prefix
        if (addr[31:20] == soc_l2_pkg::ALIAS_PREFIX) begin
            addr[31:20] = soc_l2_pkg::SOC_PREFIX;
        end
        mask = {{8{req.be[3]}}, {8{req.be[2]}}, {8{req.be[1]}}, {8{req.be[0]}}};
        rsp.rdata = '0;
        rsp.err   = 1'b0;
        if (addr >= soc_l2_pkg::L2_INTLV_START && addr <= soc_l2_pkg::L2_INTLV_END) begin
            offset = addr - soc_l2_pkg::L2_INTLV_START;
            iidx   = offset[7:2];
            if (req.op == soc_l2_pkg::OP_WRITE) begin
                intlv_model[iidx] = (intlv_model[iidx] & ~mask) | (req.wdata & mask);
            end else begin
                rsp.rdata = intlv_model[iidx];
            end
        end else if (addr >= soc_l2_pkg::PRIVATE_START && addr <= soc_l2_pkg::PRIVATE_END) begin
            offset = addr - soc_l2_pkg::PRIVATE_START;
            pidx   = offset[5:2];
            if (req.op == soc_l2_pkg::OP_WRITE) begin
                priv_model[pidx] = (priv_model[pidx] & ~mask) | (req.wdata & mask);
            end else begin
                rsp.rdata = priv_model[pidx];
            end
        end else begin
            // Outside both regions the model stays untouched
            rsp.err = 1'b1;
        end
        return rsp;
    endfunction

    ////////////////////
    // Compare
    ////////////////////
    always @(posedge clk_i) begin
        soc_l2_pkg::soc_rsp_t exp_rsp;
        if (reset_i) begin
            exp_q.delete();
            err_count_o = 0;
            rsp_count_o = 0;
        end else begin
            if (req_valid_i && req_ready_i) begin
                exp_q.push_back(expect_rsp(req_i));
            end
            if (rsp_valid_i && rsp_ready_i) begin
                rsp_count_o = rsp_count_o + 1;
                if (exp_q.size() == 0) begin
                    $display("Response at time %0t arrived with no request outstanding",
                             $time);
                    err_count_o = err_count_o + 1;
                end else begin
                    exp_rsp = exp_q.pop_front();
                    if (rsp_i !== exp_rsp) begin
                        $display("ERROR at %0t: expected rdata=%h err=%b, got rdata=%h err=%b",
                                 $time, exp_rsp.rdata, exp_rsp.err, rsp_i.rdata, rsp_i.err);
                        err_count_o = err_count_o + 1;
                    end
                end
            end
        end
        pending_o = exp_q.size();
    end

endmodule
